//--- design/avr_alu_pkg.sv
// Fixed 8-bit datapath, opcode fits 5 bits, flag struct packed in AVR SREG bit order (C is bit 0)
`default_nettype none

package avr_alu_pkg;

   // ################################################
   // Widths
   // ################################################

   // Operand and result width
   localparam int unsigned alu_data_w   = 8;
   // Half carry taken out of this nibble
   localparam int unsigned alu_nibble_w = 4;

   typedef logic [alu_data_w-1:0] alu_data_t;

   // Signed range limits for overflow checks
   localparam alu_data_t alu_min_neg = 8'h80;
   localparam alu_data_t alu_max_pos = 8'h7F;

   // ################################################
   // Opcodes
   // ################################################

   // One value per operation, immediate forms share the register code
   typedef enum logic [4:0] {
      op_nop,
      op_add,
      op_adc,
      op_sub,
      op_sbc,
      op_cp,
      op_cpc,
      op_and,
      op_or,
      op_eor,
      op_com,
      op_neg,
      op_inc,
      op_dec,
      op_lsr,
      op_ror,
      op_asr,
      op_swap
   } alu_op_t;

   // ################################################
   // Payload structs
   // ################################################

   // Status flags, MSB first so c lands on bit 0
   typedef struct packed {
      logic h;
      logic s;
      logic v;
      logic n;
      logic z;
      logic c;
   } alu_flags_t;

   // Adder result with its raw flag terms
   typedef struct packed {
      alu_data_t sum;
      logic      cout;   // carry, or borrow when subtracting
      logic      half;   // out of bit 3
      logic      ovf;
   } adder_out_t;

   // Single-operand result with its flag terms
   typedef struct packed {
      alu_data_t res;
      logic      c;
      logic      v;
      logic      h;
   } unary_out_t;

endpackage

`default_nettype wire

//--- design/avr_alu_adder.sv
// Stored carry enters only for ADC, SBC and CPC; borrow reported as a set carry, AVR style
`default_nettype none

module avr_alu_adder
   import avr_alu_pkg::*;
(
   input  wire alu_op_t   op,
   input  wire alu_data_t d_in,
   input  wire alu_data_t r_in,
   input  wire            sreg_c,
   output adder_out_t     sum_out
);

   // Subtract group
   logic                  sub_op;
   // Carry or borrow into bit 0
   logic                  cin;
   // One extra bit holds carry out of bit 7
   logic [alu_data_w:0]   full;
   // Low nibble, extra bit is the half carry
   logic [alu_nibble_w:0] low;

   assign sub_op = op inside {op_sub, op_sbc, op_cp, op_cpc};
   assign cin    = sreg_c & (op inside {op_adc, op_sbc, op_cpc});

   // ################################################
   // Add / subtract
   // ################################################

   always_comb begin
      if (sub_op) begin
         // Borrow wraps into the top bit
         full = {1'b0, d_in} - {1'b0, r_in} - cin;
         low  = {1'b0, d_in[alu_nibble_w-1:0]} - {1'b0, r_in[alu_nibble_w-1:0]} - cin;
      end else begin
         full = {1'b0, d_in} + {1'b0, r_in} + cin;
         low  = {1'b0, d_in[alu_nibble_w-1:0]} + {1'b0, r_in[alu_nibble_w-1:0]} + cin;
      end
   end

   assign sum_out.sum  = full[alu_data_w-1:0];
   assign sum_out.cout = full[alu_data_w];
   assign sum_out.half = low[alu_nibble_w];

   // Overflow, sign of result against operand signs
   assign sum_out.ovf = sub_op ?
      ((d_in[alu_data_w-1] & ~r_in[alu_data_w-1] & ~full[alu_data_w-1]) |
       (~d_in[alu_data_w-1] & r_in[alu_data_w-1] & full[alu_data_w-1])) :
      ((d_in[alu_data_w-1] & r_in[alu_data_w-1] & ~full[alu_data_w-1]) |
       (~d_in[alu_data_w-1] & ~r_in[alu_data_w-1] & full[alu_data_w-1]));

endmodule

`default_nettype wire

//--- design/avr_alu_unary.sv
// Single-operand group on d_in only; flag terms are zero for opcodes outside NEG/INC/DEC/COM
`default_nettype none

module avr_alu_unary
   import avr_alu_pkg::*;
(
   input  wire alu_op_t   op,
   input  wire alu_data_t d_in,
   output unary_out_t     un_out
);

   // Two's complement of d
   alu_data_t             neg_res;
   // Low nibble of 0 - d, top bit is the borrow
   logic [alu_nibble_w:0] neg_low;
   alu_data_t             inc_res;
   alu_data_t             dec_res;

   // ################################################
   // Arithmetic terms
   // ################################################

   assign neg_res = '0 - d_in;
   assign neg_low = '0 - {1'b0, d_in[alu_nibble_w-1:0]};
   assign inc_res = d_in + 1'b1;
   assign dec_res = d_in - 1'b1;

   // ################################################
   // Select by opcode
   // ################################################

   always_comb begin
      un_out = '0;
      case (op)
         op_neg: begin
            un_out.res = neg_res;
            // Carry clear only for NEG of zero
            un_out.c   = |neg_res;
            // 0x80 has no positive counterpart
            un_out.v   = (neg_res == alu_min_neg);
            un_out.h   = neg_low[alu_nibble_w];
         end
         op_inc: begin
            un_out.res = inc_res;
            un_out.v   = (inc_res == alu_min_neg);
         end
         op_dec: begin
            un_out.res = dec_res;
            un_out.v   = (dec_res == alu_max_pos);
         end
         op_com: begin
            un_out.res = ~d_in;
            // COM always sets carry
            un_out.c   = 1'b1;
         end
         default: begin
            un_out = '0;
         end
      endcase
   end

endmodule

`default_nettype wire

//--- design/avr_alu_bitwise.sv
// Logic ops, right shifts of d_in and nibble swap; result zero for any other opcode
`default_nettype none

module avr_alu_bitwise
   import avr_alu_pkg::*;
(
   input  wire alu_op_t   op,
   input  wire alu_data_t d_in,
   input  wire alu_data_t r_in,
   input  wire            sreg_c,
   output alu_data_t      bw_res
);

   // Bit shifted in at the top
   logic shift_msb;

   // LSR fills 0, ROR the stored carry, ASR keeps the sign
   always_comb begin
      case (op)
         op_ror:  shift_msb = sreg_c;
         op_asr:  shift_msb = d_in[alu_data_w-1];
         default: shift_msb = 1'b0;
      endcase
   end

   // ################################################
   // Result mux
   // ################################################

   always_comb begin
      case (op)
         op_and:  bw_res = d_in & r_in;
         op_or:   bw_res = d_in | r_in;
         op_eor:  bw_res = d_in ^ r_in;
         op_lsr,
         op_ror,
         op_asr:  bw_res = {shift_msb, d_in[alu_data_w-1:1]};
         // Exchange high and low nibbles
         op_swap: bw_res = {d_in[alu_nibble_w-1:0], d_in[alu_data_w-1:alu_nibble_w]};
         default: bw_res = '0;
      endcase
   end

endmodule

`default_nettype wire

//--- design/avr_alu_result_select.sv
// Purely combinational; op_nop gives a zero result with Z set, the SREG mask drops it anyway
`default_nettype none

module avr_alu_result_select
   import avr_alu_pkg::*;
(
   input  wire alu_op_t    op,
   input  wire alu_data_t  d_in,
   input  wire adder_out_t sum_out,
   input  wire unary_out_t un_out,
   input  wire alu_data_t  bw_res,
   input  wire             sreg_z,
   output alu_data_t       result,
   output alu_flags_t      flags
);

   // Opcode groups
   logic add_grp;
   logic un_grp;
   logic bw_grp;
   logic shift_grp;
   // Intermediate flag terms
   logic n_flag;
   logic c_flag;
   logic v_flag;
   logic z_flag;

   assign add_grp   = op inside {op_add, op_adc, op_sub, op_sbc, op_cp, op_cpc};
   assign un_grp    = op inside {op_com, op_neg, op_inc, op_dec};
   assign shift_grp = op inside {op_lsr, op_ror, op_asr};
   assign bw_grp    = shift_grp | (op inside {op_and, op_or, op_eor, op_swap});

   // ################################################
   // Result mux
   // ################################################

   always_comb begin
      if (add_grp) begin
         result = sum_out.sum;
      end else if (un_grp) begin
         result = un_out.res;
      end else if (bw_grp) begin
         result = bw_res;
      end else begin
         // op_nop
         result = '0;
      end
   end

   // ################################################
   // Flags
   // ################################################

   assign n_flag = result[alu_data_w-1];

   // Zero detect, chained compare keeps Z only if already set
   always_comb begin
      z_flag = (result == '0);
      if (op inside {op_sbc, op_cpc}) begin
         z_flag = z_flag & sreg_z;
      end
   end

   // Carry from the unit that owns the op
   always_comb begin
      if (add_grp) begin
         c_flag = sum_out.cout;
      end else if (un_grp) begin
         c_flag = un_out.c;
      end else if (shift_grp) begin
         // Bit shifted out
         c_flag = d_in[0];
      end else begin
         c_flag = 1'b0;
      end
   end

   // Overflow, zero for logic ops and SWAP
   always_comb begin
      if (add_grp) begin
         v_flag = sum_out.ovf;
      end else if (un_grp) begin
         v_flag = un_out.v;
      end else if (shift_grp) begin
         v_flag = n_flag ^ c_flag;
      end else begin
         v_flag = 1'b0;
      end
   end

   assign flags.c = c_flag;
   assign flags.z = z_flag;
   assign flags.n = n_flag;
   assign flags.v = v_flag;
   assign flags.s = n_flag ^ v_flag;
   // Half carry only meaningful for adder group and NEG
   assign flags.h = (add_grp & sum_out.half) | ((op == op_neg) & un_out.h);

endmodule

`default_nettype wire

//--- design/avr_sreg.sv
// Loads only the flags the opcode affects, and only while exec is high; clears on sync reset
`default_nettype none

module avr_sreg
   import avr_alu_pkg::*;
(
   input  wire             cp2,
   input  wire             rst_n,
   input  wire             exec,
   input  wire alu_op_t    op,
   input  wire alu_flags_t flags,
   output alu_flags_t      sreg,
   output logic            sreg_c,
   output logic            sreg_z
);

   // Set bit means that flag is written
   alu_flags_t upd_mask;

   // ################################################
   // Update mask per opcode
   // ################################################

   always_comb begin
      upd_mask = '0;
      case (op)
         op_add, op_adc, op_sub, op_sbc, op_cp, op_cpc,
         op_com, op_neg: begin
            upd_mask = '1;
         end
         // INC/DEC leave C and H alone
         op_inc, op_dec: begin
            upd_mask   = '1;
            upd_mask.c = 1'b0;
            upd_mask.h = 1'b0;
         end
         op_and, op_or, op_eor: begin
            upd_mask.z = 1'b1;
            upd_mask.n = 1'b1;
            upd_mask.v = 1'b1;
            upd_mask.s = 1'b1;
         end
         // Shifts touch everything but H
         op_lsr, op_ror, op_asr: begin
            upd_mask   = '1;
            upd_mask.h = 1'b0;
         end
         // SWAP and NOP change nothing
         default: begin
            upd_mask = '0;
         end
      endcase
   end

   // ################################################
   // Register
   // ################################################

   always_ff @(posedge cp2) begin
      if (!rst_n) begin
         sreg <= '0;
      end else if (exec) begin
         sreg <= alu_flags_t'((sreg & ~upd_mask) | (flags & upd_mask));
      end
   end

   // Chaining inputs for the ALU
   assign sreg_c = sreg.c;
   assign sreg_z = sreg.z;

endmodule

`default_nettype wire

//--- design/avr_alu.sv
// Single-cycle ALU; result and flags combinational, sreg updates on the cp2 edge after exec
`default_nettype none

module avr_alu
   import avr_alu_pkg::*;
(
   input  wire            cp2,
   input  wire            rst_n,
   input  wire            exec,
   input  wire alu_op_t   op,
   input  wire alu_data_t d_in,
   input  wire alu_data_t r_in,
   output alu_data_t      result,
   output alu_flags_t     flags,
   output alu_flags_t     sreg
);

   // Stored flags fed back into the datapath
   logic       sreg_c;
   logic       sreg_z;
   // Unit outputs
   adder_out_t sum_out;
   unary_out_t un_out;
   alu_data_t  bw_res;

   // ################################################
   // Datapath units
   // ################################################

   avr_alu_adder u_adder (
      .op      (op),
      .d_in    (d_in),
      .r_in    (r_in),
      .sreg_c  (sreg_c),
      .sum_out (sum_out)
   );

   avr_alu_unary u_unary (
      .op     (op),
      .d_in   (d_in),
      .un_out (un_out)
   );

   avr_alu_bitwise u_bitwise (
      .op     (op),
      .d_in   (d_in),
      .r_in   (r_in),
      .sreg_c (sreg_c),
      .bw_res (bw_res)
   );

   // Final mux and flag formation
   avr_alu_result_select u_result_select (
      .op      (op),
      .d_in    (d_in),
      .sum_out (sum_out),
      .un_out  (un_out),
      .bw_res  (bw_res),
      .sreg_z  (sreg_z),
      .result  (result),
      .flags   (flags)
   );

   // ################################################
   // Status register
   // ################################################

   avr_sreg u_sreg (
      .cp2    (cp2),
      .rst_n  (rst_n),
      .exec   (exec),
      .op     (op),
      .flags  (flags),
      .sreg   (sreg),
      .sreg_c (sreg_c),
      .sreg_z (sreg_z)
   );

endmodule

`default_nettype wire

//--- test/tb_clock_gen.sv
// Free-running 20 ns clock; rst_n held low for the first 10 rising edges, released on a falling edge
`default_nettype none

module tb_clock_gen (
   output logic cp2,
   output logic rst_n
);
   timeunit 1ns;
   timeprecision 100ps;

   localparam int half_period_ns = 10;
   localparam int reset_cycles   = 10;

   initial begin
      cp2 = 1'b0;
      forever #half_period_ns cp2 = ~cp2;
   end

   // Sync reset, let it see a few edges before release
   initial begin
      rst_n = 1'b0;
      repeat (reset_cycles) @(posedge cp2);
      @(negedge cp2);
      rst_n = 1'b1;
   end

endmodule

`default_nettype wire

//--- test/avr_alu_tb.sv
// Inputs change on the falling edge, outputs sampled 1 ns before the rising edge; fixed LCG seed
`default_nettype none

module avr_alu_tb
   import avr_alu_pkg::*;
;
   timeunit 1ns;
   timeprecision 100ps;

   // ##################################################
   // Run length and watchdog limit
   // ##################################################

   localparam int clk_period_ns = 20;
   localparam int check_delay_ns = 9;
   localparam int n_random = 2000;
   localparam int n_chain = 60;
   localparam int total_cycles = 10 + n_random + 4 * n_chain + 5 + 4;
   localparam int timeout_ns = total_cycles * clk_period_ns * 3 / 2;

   logic       cp2;
   logic       rst_n;
   logic       exec;
   alu_op_t    op;
   alu_data_t  d_in;
   alu_data_t  r_in;
   alu_data_t  result;
   alu_flags_t flags;
   alu_flags_t sreg;

   // Model state and captured outputs
   alu_flags_t  model_sreg;
   alu_data_t   last_result;
   alu_flags_t  last_flags;
   logic [31:0] rng_state;
   int          err_result;
   int          err_flags;
   int          err_sreg;
   int          err_chain;
   int          err_other;

   tb_clock_gen u_clock_gen (
      .cp2   (cp2),
      .rst_n (rst_n)
   );

   avr_alu dut (
      .cp2    (cp2),
      .rst_n  (rst_n),
      .exec   (exec),
      .op     (op),
      .d_in   (d_in),
      .r_in   (r_in),
      .result (result),
      .flags  (flags),
      .sreg   (sreg)
   );

   // ##################################################
   // Random numbers and reference model
   // ##################################################

   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Returns {flags, result} from the instruction set rules
   function automatic logic [13:0] alu_model(alu_op_t o, alu_data_t d, alu_data_t r,
                                              logic c_in, logic z_in);
      alu_flags_t f;
      alu_data_t  res;
      int         ci;
      int         wide;
      int         low;
      int         sd;
      f   = '0;
      res = '0;
      // Stored carry only for the chained forms
      ci  = (c_in && (o inside {op_adc, op_sbc, op_cpc})) ? 1 : 0;
      case (o)
         op_add, op_adc: begin
            wide = int'(d) + int'(r) + ci;
            low  = int'(d[3:0]) + int'(r[3:0]) + ci;
            sd   = int'($signed(d)) + int'($signed(r)) + ci;
            res  = wide[7:0];
            f.c  = wide > 255;
            f.h  = low > 15;
            f.v  = (sd > 127) || (sd < -128);
         end
         op_sub, op_sbc, op_cp, op_cpc: begin
            wide = int'(d) - int'(r) - ci;
            low  = int'(d[3:0]) - int'(r[3:0]) - ci;
            sd   = int'($signed(d)) - int'($signed(r)) - ci;
            res  = wide[7:0];
            f.c  = wide < 0;
            f.h  = low < 0;
            f.v  = (sd > 127) || (sd < -128);
         end
         op_and:  res = d & r;
         op_or:   res = d | r;
         op_eor:  res = d ^ r;
         op_com: begin
            res = 8'hFF - d;
            f.c = 1'b1;
         end
         op_neg: begin
            wide = 0 - int'(d);
            res  = wide[7:0];
            f.c  = d != 8'h00;
            f.v  = d == 8'h80;
            f.h  = d[3:0] != 4'h0;
         end
         op_inc: begin
            res = d + 8'd1;
            f.v = d == 8'h7F;
         end
         op_dec: begin
            res = d - 8'd1;
            f.v = d == 8'h80;
         end
         op_lsr:  res = d >> 1;
         op_ror:  res = {c_in, d[7:1]};
         op_asr:  res = {d[7], d[7:1]};
         op_swap: res = {d[3:0], d[7:4]};
         default: res = '0;
      endcase
      f.n = res[7];
      f.z = (res == 8'h00) && (!(o inside {op_sbc, op_cpc}) || z_in);
      // Shift carry is the bit shifted out
      if (o inside {op_lsr, op_ror, op_asr}) begin
         f.c = d[0];
         f.v = f.n ^ f.c;
      end
      f.s = f.n ^ f.v;
      return {f, res};
   endfunction

   // Which stored flags an operation may write
   function automatic alu_flags_t sreg_update(alu_op_t o, alu_flags_t old, alu_flags_t f);
      alu_flags_t nxt;
      logic       arith;
      logic       incdec;
      logic       logic_op;
      logic       shift;
      nxt      = old;
      arith    = o inside {op_add, op_adc, op_sub, op_sbc, op_cp, op_cpc, op_com, op_neg};
      incdec   = o inside {op_inc, op_dec};
      logic_op = o inside {op_and, op_or, op_eor};
      shift    = o inside {op_lsr, op_ror, op_asr};
      if (arith || incdec || logic_op || shift) begin
         nxt.z = f.z;
         nxt.n = f.n;
         nxt.v = f.v;
         nxt.s = f.s;
      end
      if (arith || shift) begin
         nxt.c = f.c;
      end
      if (arith) begin
         nxt.h = f.h;
      end
      return nxt;
   endfunction

   // ##################################################
   // One operation per cycle
   // ##################################################

   task automatic run_op(alu_op_t o, alu_data_t d, alu_data_t r, logic ex);
      logic [13:0] exp_v;
      alu_flags_t  held;
      @(negedge cp2);
      op    = o;
      d_in  = d;
      r_in  = r;
      exec  = ex;
      exp_v = alu_model(o, d, r, model_sreg.c, model_sreg.z);
      held  = sreg;
      #check_delay_ns;
      assert (result === exp_v[7:0]) else begin
         $display("** Error: result = 0x%02h, expected 0x%02h (op %s, d 0x%02h, r 0x%02h)",
                  result, exp_v[7:0], o.name(), d, r);
         err_result++;
      end
      assert (flags === exp_v[13:8]) else begin
         $display("** Error: flags = 0x%02h, expected 0x%02h (op %s, d 0x%02h, r 0x%02h)",
                  flags, exp_v[13:8], o.name(), d, r);
         err_flags++;
      end
      assert (sreg === model_sreg) else begin
         $display("** Error: sreg = 0x%02h, expected 0x%02h", sreg, model_sreg);
         err_sreg++;
      end
      last_result = result;
      last_flags  = flags;
      @(posedge cp2);
      if (ex) begin
         model_sreg = sreg_update(o, model_sreg, exp_v[13:8]);
      end
      #1;
      // Idle cycles and SWAP or NOP leave the register alone
      if (!ex || (o inside {op_swap, op_nop})) begin
         assert (sreg === held) else begin
            $display("** Error: sreg = 0x%02h after %s with exec %0b, expected 0x%02h",
                     sreg, o.name(), ex, held);
            err_other++;
         end
      end
   endtask

   task automatic check_edge(string what, logic [7:0] exp_res, logic exp_c, logic exp_v,
                             logic exp_h);
      assert ({last_result, last_flags.c, last_flags.v, last_flags.h} ===
              {exp_res, exp_c, exp_v, exp_h}) else begin
         $display("** Error: %s result/c/v/h = 0x%02h/%0h/%0h/%0h, expected 0x%02h/%0h/%0h/%0h",
                  what, last_result, last_flags.c, last_flags.v, last_flags.h,
                  exp_res, exp_c, exp_v, exp_h);
         err_other++;
      end
   endtask

   // ##################################################
   // Watchdog
   // ##################################################

   initial begin
      #(timeout_ns);
      $display("Timeout: run did not complete within %0d ns", timeout_ns);
      $display("=== FAIL ===");
      $finish;
   end

   // ##################################################
   // Test phases
   // ##################################################

   initial begin
      logic [15:0] a;
      logic [15:0] b;
      logic [16:0] sum17;
      alu_data_t   lo;
      alu_data_t   hi;
      alu_op_t     o;
      alu_data_t   d;
      logic        ex;
      int          total;
      exec       = 1'b0;
      op         = op_nop;
      d_in       = '0;
      r_in       = '0;
      model_sreg = '0;
      rng_state  = 32'h775b_2cfb;
      err_result = 0;
      err_flags  = 0;
      err_sreg   = 0;
      err_chain  = 0;
      err_other  = 0;

      wait (rst_n === 1'b1);
      assert (sreg === '0) else begin
         $display("** Error: sreg = 0x%02h after reset, expected 0x00", sreg);
         err_sreg++;
      end

      // Random ops with exec low about one cycle in four
      for (int i = 0; i < n_random; i++) begin
         rng_state = lcg_step(rng_state);
         o         = alu_op_t'(rng_state[31:27] % 18);
         d         = rng_state[23:16];
         ex        = rng_state[9:8] != 2'b00;
         rng_state = lcg_step(rng_state);
         run_op(o, d, rng_state[23:16], ex);
      end

      // Two-byte add and compare chains
      for (int i = 0; i < n_chain; i++) begin
         rng_state = lcg_step(rng_state);
         a         = rng_state[31:16];
         rng_state = lcg_step(rng_state);
         b         = rng_state[31:16];
         // Equal words and equal high bytes now and then
         if (i % 4 == 0) begin
            b = a;
         end else if (i % 4 == 1) begin
            b[15:8] = a[15:8];
         end
         sum17 = {1'b0, a} + {1'b0, b};
         run_op(op_add, a[7:0], b[7:0], 1'b1);
         lo = last_result;
         run_op(op_adc, a[15:8], b[15:8], 1'b1);
         hi = last_result;
         assert ({sreg.c, hi, lo} === sum17) else begin
            $display("** Error: 16-bit sum = 0x%05h, expected 0x%05h", {sreg.c, hi, lo}, sum17);
            err_chain++;
         end
         run_op(op_cp, a[7:0], b[7:0], 1'b1);
         run_op(op_cpc, a[15:8], b[15:8], 1'b1);
         assert (sreg.z === (a == b) && sreg.c === (a < b)) else begin
            $display("** Error: sreg.z/c = 0x%0h/0x%0h after CPC, expected 0x%0h/0x%0h",
                     sreg.z, sreg.c, a == b, a < b);
            err_chain++;
         end
      end

      // Edge operands
      run_op(op_neg, 8'h00, 8'h00, 1'b1);
      check_edge("NEG 0x00", 8'h00, 1'b0, 1'b0, 1'b0);
      run_op(op_neg, 8'h80, 8'h00, 1'b1);
      check_edge("NEG 0x80", 8'h80, 1'b1, 1'b1, 1'b0);
      run_op(op_inc, 8'h7F, 8'h00, 1'b1);
      check_edge("INC 0x7F", 8'h80, 1'b0, 1'b1, 1'b0);
      run_op(op_dec, 8'h80, 8'h00, 1'b1);
      check_edge("DEC 0x80", 8'h7F, 1'b0, 1'b1, 1'b0);
      run_op(op_add, 8'hFF, 8'h01, 1'b1);
      check_edge("ADD 0xFF+0x01", 8'h00, 1'b1, 1'b0, 1'b1);

      total = err_result + err_flags + err_sreg + err_chain + err_other;
      $display("Errors: result %0d, flags %0d, sreg %0d, chain %0d, other %0d",
               err_result, err_flags, err_sreg, err_chain, err_other);
      if (total == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- all.f
design/avr_alu_pkg.sv
design/avr_alu_adder.sv
design/avr_alu_unary.sv
design/avr_alu_bitwise.sv
design/avr_alu_result_select.sv
design/avr_sreg.sv
design/avr_alu.sv
test/tb_clock_gen.sv
test/avr_alu_tb.sv

//--- Bender.yml
package:
  name: avr_alu

sources:
  - design/avr_alu_pkg.sv
  - design/avr_alu_adder.sv
  - design/avr_alu_unary.sv
  - design/avr_alu_bitwise.sv
  - design/avr_alu_result_select.sv
  - design/avr_sreg.sv
  - design/avr_alu.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/avr_alu_tb.sv
